/* filelist.f */
rtl/astro_cfg_pkg.sv
rtl/astro_input_pkg.sv
rtl/game_config.sv
rtl/ps2_button_decoder.sv
rtl/paddle_conditioner.sv
rtl/stick_axis_mapper.sv
rtl/switch_matrix.sv
rtl/astro_input_top.sv
dv/tb_astro_input.sv

/* build.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_astro_input -f filelist.f -o tb_astro_input
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/tb_astro_input)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "all tests passed"; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1

/* dv/tb_astro_input.sv */
// Testbench for the arcade player input subsystem.
// Drives downloads, PS/2 keys, joysticks and analog sticks, then reads every column
// and compares the row byte with a reference model kept inside the testbench.

`timescale 1ns/100ps

module tb_astro_input;

	import astro_cfg_pkg::*;
	import astro_input_pkg::*;

	localparam int KEY_STEPS   = 24;
	localparam int JOY_STEPS   = 24;
	localparam int STICK_STEPS = 32;
	localparam int BOGUS_STEPS = 16;
	localparam int NUM_CHECKS  = 7 + 2 * KEY_STEPS + 2 * JOY_STEPS + STICK_STEPS + BOGUS_STEPS;
	// Game load, settle time and seven column reads
	localparam int CYCLES_PER_CHECK = 24;
	localparam int TIMEOUT_CYCLES   = 2 * (16 + NUM_CHECKS * CYCLES_PER_CHECK);

	localparam game_id_t GAME_ORDER [0:5] = '{GAME_SPACEZAP, GAME_GORF, GAME_WOW,
		GAME_ROBBY, GAME_EBASES, GAME_SEAWOLF2};
	// Mapped keys, last entry is an unmapped key
	localparam logic [8:0] KEY_CODES [0:18] = '{9'h075, 9'h072, 9'h06B, 9'h074, 9'h014,
		9'h029, 9'h005, 9'h016, 9'h006, 9'h01E, 9'h004, 9'h02E, 9'h02D, 9'h02B, 9'h023,
		9'h034, 9'h01C, 9'h01B, 9'h01D};

	logic        clk_sys;
	logic        reset;
	download_t   dl;
	logic [10:0] ps2_key;
	logic [15:0] joystick_0;
	logic [15:0] joystick_1;
	logic [15:0] joystick_a0;
	logic [15:0] joystick_a1;
	logic        speech_busy;
	logic [7:0]  col_select;
	logic [7:0]  row_data;

	// Testbench copy of the loaded game, DIPs and held keys
	game_id_t     m_game;
	dip_bank_t    m_dips;
	logic [255:0] key_held;
	logic         ps2_toggle;
	logic [31:0]  rng_state;
	int           check_requests;
	int           checks_done;
	int           mismatches;
	int           tests_run;
	int           tests_failing;
	int           cycle_count;

	astro_input_top #(.AXIS_BITS(3)) UUT (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl          (dl),
		.ps2_key     (ps2_key),
		.joystick_0  (joystick_0),
		.joystick_1  (joystick_1),
		.joystick_a0 (joystick_a0),
		.joystick_a1 (joystick_a1),
		.speech_busy (speech_busy),
		.col_select  (col_select),
		.row_data    (row_data)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// ============================================================
	// Random numbers and reference model
	// ============================================================
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic roll(output logic [31:0] value);
		rng_state = lcg_next(rng_state);
		// Fold high bits down, LCG low bits are weak
		value = rng_state ^ (rng_state >> 16);
	endtask

	// R L D U, active low
	function automatic logic [3:0] pad_nibble(input player_buttons_t b);
		return {!b.right, !b.left, !b.down, !b.up};
	endfunction

	// Move, R L D U from raw 3 bit X and Y positions, active low
	function automatic logic [4:0] stick_nibble(input logic [2:0] x, input logic [2:0] y);
		logic mv;
		mv = (x == 3'd0) || (x == 3'd7) || (y == 3'd0) || (y == 3'd7);
		return {!mv, !(x >= 3'd5), !(x <= 3'd2), !(y <= 3'd2), !(y >= 3'd5)};
	endfunction

	function automatic logic [7:0] expected_row(input logic [7:0] col);
		player_buttons_t b1;
		player_buttons_t b2;
		logic [7:0]      pos [0:3];
		logic [7:0]      d2;
		logic [7:0]      c1;
		logic [7:0]      c2;
		logic [7:0]      c4;
		b1.up    = key_held[8'h75] | joystick_0[3];
		b1.down  = key_held[8'h72] | joystick_0[2];
		b1.left  = key_held[8'h6B] | joystick_0[1];
		b1.right = key_held[8'h74] | joystick_0[0];
		b1.fire1 = key_held[8'h14] | joystick_0[4];
		b1.fire2 = key_held[8'h29] | joystick_0[5];
		b1.start = key_held[8'h05] | key_held[8'h16] | joystick_0[6];
		b1.coin  = key_held[8'h04] | key_held[8'h2E] | joystick_0[8];
		b2.up    = key_held[8'h2D] | joystick_1[3];
		b2.down  = key_held[8'h2B] | joystick_1[2];
		b2.left  = key_held[8'h23] | joystick_1[1];
		b2.right = key_held[8'h34] | joystick_1[0];
		b2.fire1 = key_held[8'h1C] | joystick_1[4];
		b2.fire2 = key_held[8'h1B] | joystick_1[5];
		// Start 2 lives on the first pad
		b2.start = key_held[8'h06] | key_held[8'h1E] | joystick_0[7];
		b2.coin  = 1'b0;
		// Offset binary X; Y is negated then offset, 127 - y mod 256
		pos[0] = joystick_a0[7:0] + 8'd128;
		pos[1] = 8'd127 - joystick_a0[15:8];
		pos[2] = joystick_a1[7:0] + 8'd128;
		pos[3] = 8'd127 - joystick_a1[15:8];
		d2 = m_dips[2];
		c1 = 8'hFF;
		c2 = 8'hFF;
		c4 = 8'hFF;
		case (m_game)
			GAME_SPACEZAP: begin
				c1 = {2'b11, ~b2.start, ~b1.start, d2[1], 1'b1, ~b1.coin, 1'b1};
				c2 = {3'b111, ~b2.fire1, pad_nibble(b2)};
				c4 = {2'b11, d2[0], ~b1.fire1, pad_nibble(b1)};
			end
			GAME_WOW: begin
				c1 = {d2[2], ~b2.start, ~b1.start, 1'b1, d2[1], 1'b1, ~b1.coin, 1'b1};
				c2 = m_dips[0][1] ? {2'b11, ~b2.fire1, stick_nibble(pos[2][7:5], pos[3][7:5])}
					: {2'b11, ~b2.fire1, b2.fire2, pad_nibble(b2)};
				c4 = m_dips[0][0] ?
					{speech_busy, 1'b1, ~b1.fire1, stick_nibble(pos[0][7:5], pos[1][7:5])}
					: {speech_busy, 1'b1, ~b1.fire1, b1.fire2, pad_nibble(b1)};
			end
			GAME_GORF: begin
				c1 = {d2[2], d2[0], ~b2.start, ~b1.start, 1'b1, d2[1], ~b1.coin, 1'b1};
				c2 = {3'b001, ~b2.fire1, pad_nibble(b2)};
				c4 = {speech_busy, 2'b01, ~b1.fire1, pad_nibble(b1)};
			end
			GAME_ROBBY: begin
				c1 = {1'b0, ~b2.start, ~b1.start, 1'b1, d2[1], 1'b1, ~b1.coin, 1'b1};
				c2 = {2'b11, ~b2.fire1, 1'b1, pad_nibble(b2)};
				c4 = {2'b11, ~b1.fire1, 1'b1, pad_nibble(b1)};
			end
			default: ;
		endcase
		case (col)
			8'h01:   return c1;
			8'h02:   return c2;
			8'h04:   return c4;
			8'h08:   return m_dips[3];
			default: return 8'hFF;
		endcase
	endfunction

	// ============================================================
	// Stimulus helpers, inputs change 1 ns after the rising edge
	// ============================================================
	task automatic write_download(input logic [7:0] index, input logic [24:0] addr,
		input logic [7:0] data);
		@(posedge clk_sys);
		#1;
		dl.wr    = 1'b1;
		dl.index = index;
		dl.addr  = addr;
		dl.data  = data;
		@(posedge clk_sys);
		#1;
		dl.wr = 1'b0;
	endtask

	task automatic load_game(input game_id_t game, input logic [31:0] dip_word);
		write_download(GAME_INDEX, 25'd0, game);
		for (int n = 0; n < 4; n++) begin
			write_download(DIP_INDEX, 25'(n), dip_word[8*n +: 8]);
			m_dips[n] = dip_word[8*n +: 8];
		end
		m_game = game;
	endtask

	task automatic send_key(input logic [8:0] code, input logic pressed);
		@(posedge clk_sys);
		#1;
		ps2_toggle = !ps2_toggle;
		ps2_key = {ps2_toggle, pressed, code};
		// Prefixed cursor codes land on the same key
		key_held[code[7:0]] = pressed;
	endtask

	// Hands the settled inputs to the compare process and waits for it
	task automatic check_rows();
		check_requests++;
		wait (checks_done == check_requests);
	endtask

	task automatic finish_test(input string name, input int mark);
		tests_run++;
		if (mismatches == mark) begin
			$display("test %0d %s: pass", tests_run, name);
		end else begin
			tests_failing++;
			$display("test %0d %s: FAIL with %0d mismatches", tests_run, name,
				mismatches - mark);
		end
	endtask

	// ============================================================
	// Compare process, sweeps all columns once rows have settled
	// ============================================================
	initial begin : compare_rows
		logic [7:0] col;
		logic [7:0] expected;
		col_select = 8'h00;
		checks_done = 0;
		mismatches = 0;
		forever begin
			wait (check_requests != checks_done);
			// Worst input to row path is 3 cycles
			repeat (4) @(posedge clk_sys);
			for (int i = 0; i < 7; i++) begin
				col = (i == 6) ? 8'h03 : 8'(1 << i);
				@(posedge clk_sys);
				#1;
				col_select = col;
				@(negedge clk_sys);
				expected = expected_row(col);
				assert (row_data === expected) else begin
					$display("FAILED %0t: game %0d col %02h row %02h expected %02h",
						$time, m_game, col, row_data, expected);
					mismatches++;
				end
			end
			checks_done++;
		end
	end

	initial begin : watchdog
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk_sys);
			cycle_count++;
		end
		$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("tests failed");
		$finish;
	end

	// ============================================================
	// Test sequence
	// ============================================================
	initial begin : stimulus
		logic [31:0] r;
		logic [7:0]  idx;
		int          k;
		int          mark;
		rng_state = 32'h1cb6_9e22;
		reset = 1'b1;
		dl = '0;
		ps2_key = '0;
		joystick_0 = '0;
		joystick_1 = '0;
		joystick_a0 = '0;
		joystick_a1 = '0;
		speech_busy = 1'b0;
		m_game = '0;
		m_dips = '0;
		key_held = '0;
		ps2_toggle = 1'b0;
		check_requests = 0;
		tests_run = 0;
		tests_failing = 0;
		repeat (16) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		// No game after reset, col 08 reads cleared DIPs
		mark = mismatches;
		check_rows();
		finish_test("reset state", mark);

		mark = mismatches;
		for (int n = 0; n < 6; n++) begin
			roll(r);
			load_game(GAME_ORDER[n], r);
			check_rows();
		end
		finish_test("game and DIP load", mark);

		// Keys mixed with occasional joystick bits
		mark = mismatches;
		for (int g = 0; g < 2; g++) begin
			roll(r);
			load_game((g == 0) ? GAME_SPACEZAP : GAME_ROBBY, r);
			for (k = 0; k < KEY_STEPS; k++) begin
				roll(r);
				idx = 8'(int'(r[31:24]) % 19);
				send_key(KEY_CODES[idx] | {(idx < 8'd4) && r[23], 8'h00}, r[22]);
				if (r[21:20] == 2'b00) begin
					@(posedge clk_sys);
					#1;
					joystick_0 = {7'd0, r[8:0]};
					joystick_1 = {10'd0, r[15:10]};
				end
				check_rows();
			end
		end
		finish_test("PS/2 keys", mark);

		mark = mismatches;
		for (k = 0; k < 19; k++) begin
			send_key(KEY_CODES[k], 1'b0);
		end
		for (int g = 0; g < 2; g++) begin
			roll(r);
			load_game((g == 0) ? GAME_GORF : GAME_WOW, {r[31:8], 8'h00});
			for (k = 0; k < JOY_STEPS; k++) begin
				roll(r);
				@(posedge clk_sys);
				#1;
				joystick_0 = r[15:0];
				joystick_1 = r[31:16];
				speech_busy = r[7] ^ r[20];
				check_rows();
			end
		end
		finish_test("joysticks and speech busy", mark);

		// Wizard of Wor analog mode on both players
		mark = mismatches;
		roll(r);
		load_game(GAME_WOW, {r[31:8], r[7:2], 2'b11});
		for (k = 0; k < STICK_STEPS; k++) begin
			roll(r);
			@(posedge clk_sys);
			#1;
			joystick_a0 = r[15:0];
			joystick_a1 = r[31:16];
			speech_busy = r[9];
			check_rows();
		end
		finish_test("analog sticks", mark);

		// Writes that the capture logic has to ignore
		mark = mismatches;
		for (k = 0; k < BOGUS_STEPS; k++) begin
			roll(r);
			if (k % 2 == 0) begin
				write_download(DIP_INDEX, {22'd0, 1'b1, r[1:0]}, r[31:24]);
			end else begin
				idx = r[15:8];
				if (idx == GAME_INDEX || idx == DIP_INDEX) begin
					idx = 8'h55;
				end
				write_download(idx, {23'd0, r[17:16]}, r[31:24]);
			end
			check_rows();
		end
		finish_test("ignored downloads", mark);

		$display("summary: %0d tests run, %0d passed, %0d failed, %0d mismatches",
			tests_run, tests_run - tests_failing, tests_failing, mismatches);
		if (tests_failing == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

/* rtl/astro_input_top.sv */
// Top level of the player input subsystem.
// Wires download capture, key decode, stick conditioning and the switch matrix.

`timescale 1ns/100ps

module astro_input_top #(
	parameter int AXIS_BITS = 3
) (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  astro_cfg_pkg::download_t dl,
	input  logic [10:0]              ps2_key,
	input  logic [15:0]              joystick_0,
	input  logic [15:0]              joystick_1,
	input  logic [15:0]              joystick_a0,
	input  logic [15:0]              joystick_a1,
	input  logic                     speech_busy,
	input  logic [7:0]               col_select,
	output logic [7:0]               row_data
);

	import astro_cfg_pkg::*;
	import astro_input_pkg::*;

	game_sel_t                         game_sel;
	dip_bank_t                         dips;
	player_buttons_t                   p1;
	player_buttons_t                   p2;
	logic [NUM_AXES-1:0][AXIS_BITS-1:0] axis;
	stick_dir_t [NUM_AXES-1:0]         dir;

	game_config u_game_config (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.dl       (dl),
		.game_sel (game_sel),
		.dips     (dips)
	);

	ps2_button_decoder u_buttons (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.ps2_key    (ps2_key),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.p1         (p1),
		.p2         (p2)
	);

	paddle_conditioner #(.AXIS_BITS(AXIS_BITS)) u_paddles (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.joystick_a0 (joystick_a0),
		.joystick_a1 (joystick_a1),
		.axis        (axis)
	);

	// One mapper per analog axis
	for (genvar i = 0; i < NUM_AXES; i++) begin : g_axis
		stick_axis_mapper #(.AXIS_BITS(AXIS_BITS)) u_mapper (
			.clk_sys (clk_sys),
			.reset   (reset),
			.axis    (axis[i]),
			.dir     (dir[i])
		);
	end

	switch_matrix u_matrix (
		.game_sel    (game_sel),
		.dips        (dips),
		.p1          (p1),
		.p2          (p2),
		.dir         (dir),
		.speech_busy (speech_busy),
		.col_select  (col_select),
		.row_data    (row_data)
	);

endmodule

/* rtl/switch_matrix.sv */
// Switch row decode for the custom chip's column strobe.
// Builds the row byte for the strobed column from the loaded game's layout.

`timescale 1ns/100ps

module switch_matrix (
	input  astro_cfg_pkg::game_sel_t        game_sel,
	input  astro_cfg_pkg::dip_bank_t        dips,
	input  astro_input_pkg::player_buttons_t p1,
	input  astro_input_pkg::player_buttons_t p2,
	input  astro_input_pkg::stick_dir_t [astro_input_pkg::NUM_AXES-1:0] dir,
	input  logic                            speech_busy,
	input  logic [7:0]                      col_select,
	output logic [7:0]                      row_data
);

	import astro_input_pkg::*;

	logic [7:0] row_c0;
	logic [7:0] row_c1;
	logic [7:0] row_c2;
	logic [3:0] p1_pad;
	logic [3:0] p2_pad;
	logic [4:0] p1_stick;
	logic [4:0] p2_stick;

	// Direction nibble R L D U, active low
	function automatic logic [3:0] pad_bits(input player_buttons_t b);
		return ~{b.right, b.left, b.down, b.up};
	endfunction

	// Move flag plus R L D U from the X and Y mappers, active low
	function automatic logic [4:0] stick_bits(input stick_dir_t x, input stick_dir_t y);
		return ~{x.move | y.move, x.dir1, x.dir0, y.dir0, y.dir1};
	endfunction

	assign p1_pad   = pad_bits(p1);
	assign p2_pad   = pad_bits(p2);
	assign p1_stick = stick_bits(dir[AXIS_P1_X], dir[AXIS_P1_Y]);
	assign p2_stick = stick_bits(dir[AXIS_P2_X], dir[AXIS_P2_Y]);

	// ============================================================
	// Per game layouts for columns 01, 02 and 04
	// ============================================================
	always_comb begin
		row_c0 = 8'hFF;
		row_c1 = 8'hFF;
		row_c2 = 8'hFF;
		if (game_sel.spacezap) begin
			row_c0 = {2'b11, ~p2.start, ~p1.start, dips[2][1], 1'b1, ~p1.coin, 1'b1};
			row_c1 = {3'b111, ~p2.fire1, p2_pad};
			row_c2 = {2'b11, dips[2][0], ~p1.fire1, p1_pad};
		end else if (game_sel.gorf) begin
			row_c0 = {dips[2][2], dips[2][0], ~p2.start, ~p1.start,
				1'b1, dips[2][1], ~p1.coin, 1'b1};
			row_c1 = {3'b001, ~p2.fire1, p2_pad};
			row_c2 = {speech_busy, 2'b01, ~p1.fire1, p1_pad};
		end else if (game_sel.wow) begin
			row_c0 = {dips[2][2], ~p2.start, ~p1.start, 1'b1,
				dips[2][1], 1'b1, ~p1.coin, 1'b1};
			// Fire 2 reads uninverted in digital mode
			if (dips[0][1]) begin
				row_c1 = {2'b11, ~p2.fire1, p2_stick};
			end else begin
				row_c1 = {2'b11, ~p2.fire1, p2.fire2, p2_pad};
			end
			if (dips[0][0]) begin
				row_c2 = {speech_busy, 1'b1, ~p1.fire1, p1_stick};
			end else begin
				row_c2 = {speech_busy, 1'b1, ~p1.fire1, p1.fire2, p1_pad};
			end
		end else if (game_sel.robby) begin
			row_c0 = {1'b0, ~p2.start, ~p1.start, 1'b1, dips[2][1], 1'b1, ~p1.coin, 1'b1};
			row_c1 = {2'b11, ~p2.fire1, 1'b1, p2_pad};
			row_c2 = {2'b11, ~p1.fire1, 1'b1, p1_pad};
		end
	end

	// Column 08 is DIP byte 3 for every game
	always_comb begin
		case (col_select)
			8'h01:   row_data = row_c0;
			8'h02:   row_data = row_c1;
			8'h04:   row_data = row_c2;
			8'h08:   row_data = dips[3];
			default: row_data = 8'hFF;
		endcase
	end

endmodule

/* rtl/stick_axis_mapper.sv */
// Maps one coarse stick axis onto a direction pair and a move flag.
// Used once per axis for the Wizard of Wor analog control mode.

`timescale 1ns/100ps

module stick_axis_mapper #(
	parameter int AXIS_BITS = 3
) (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic [AXIS_BITS-1:0]        axis,
	output astro_input_pkg::stick_dir_t dir
);

	// Thresholds at a quarter of the range from each end
	localparam logic [AXIS_BITS-1:0] AXIS_MAX = '1;
	localparam logic [AXIS_BITS-1:0] LOW_MAX  = AXIS_BITS'((2 ** AXIS_BITS) / 4);
	localparam logic [AXIS_BITS-1:0] HIGH_MIN = AXIS_MAX - LOW_MAX;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			dir <= '0;
		end else begin
			dir.dir0 <= axis <= LOW_MAX;
			dir.dir1 <= axis >= HIGH_MIN;
			// Only the end stops count as a move
			dir.move <= (axis == '0) || (axis == AXIS_MAX);
		end
	end

endmodule

/* rtl/paddle_conditioner.sv */
// Turns the signed analog stick bytes into four unsigned, registered axes.
// Y bytes are inverted so that a high value means up.

`timescale 1ns/100ps

module paddle_conditioner #(
	parameter int AXIS_BITS = 3
) (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic [15:0] joystick_a0,
	input  logic [15:0] joystick_a1,
	output logic [astro_input_pkg::NUM_AXES-1:0][AXIS_BITS-1:0] axis
);

	import astro_input_pkg::*;

	logic [NUM_AXES-1:0][7:0] centered;

	// Offset signed bytes to 0..255 with the rest position at 128
	always_comb begin
		centered[AXIS_P1_X] = joystick_a0[7:0] + 8'd128;
		centered[AXIS_P1_Y] = ~joystick_a0[15:8] + 8'd128;
		centered[AXIS_P2_X] = joystick_a1[7:0] + 8'd128;
		centered[AXIS_P2_Y] = ~joystick_a1[15:8] + 8'd128;
	end

	// Keep only the coarse top bits
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			axis <= '0;
		end else begin
			for (int i = 0; i < NUM_AXES; i++) begin
				axis[i] <= centered[i][7 -: AXIS_BITS];
			end
		end
	end

endmodule

/* rtl/ps2_button_decoder.sv */
// Decodes PS/2 key events into player buttons and merges the joystick bits.
// A key event is marked by a change of the toggle bit; outputs are registered.

`timescale 1ns/100ps

module ps2_button_decoder (
	input  logic                             clk_sys,
	input  logic                             reset,
	input  logic [10:0]                      ps2_key,
	input  logic [15:0]                      joystick_0,
	input  logic [15:0]                      joystick_1,
	output astro_input_pkg::player_buttons_t p1,
	output astro_input_pkg::player_buttons_t p2
);

	import astro_input_pkg::*;

	// Held key state, one bit per mapped key
	typedef struct packed {
		logic up, down, left, right, ctrl, space;
	} p1_keys_t;
	typedef struct packed {
		logic r, f, d, g, a, s;
	} p2_keys_t;
	// Start and coin keys, function row and MAME style digits
	typedef struct packed {
		logic f1, f2, f3, one, two, five;
	} sys_keys_t;

	p1_keys_t        p1_key;
	p2_keys_t        p2_key;
	sys_keys_t       sys_key;
	player_buttons_t p1_next;
	player_buttons_t p2_next;
	logic            toggle_prev;
	logic            key_event;
	logic            pressed;
	logic [8:0]      code;

	assign pressed   = ps2_key[9];
	assign code      = ps2_key[8:0];
	assign key_event = ps2_key[10] != toggle_prev;

	// ============================================================
	// Key event capture
	// ============================================================
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			toggle_prev <= 1'b0;
			p1_key      <= '0;
			p2_key      <= '0;
			sys_key     <= '0;
		end else begin
			toggle_prev <= ps2_key[10];
			if (key_event) begin
				case (code)
					// Cursor keys, with or without the extended prefix
					9'h075, 9'h175: p1_key.up    <= pressed;
					9'h072, 9'h172: p1_key.down  <= pressed;
					9'h06B, 9'h16B: p1_key.left  <= pressed;
					9'h074, 9'h174: p1_key.right <= pressed;
					9'h014: p1_key.ctrl  <= pressed;
					9'h029: p1_key.space <= pressed;
					9'h005: sys_key.f1   <= pressed;
					9'h006: sys_key.f2   <= pressed;
					9'h004: sys_key.f3   <= pressed;
					9'h016: sys_key.one  <= pressed;
					9'h01E: sys_key.two  <= pressed;
					9'h02E: sys_key.five <= pressed;
					// Player 2 on R F D G, fire on A and S
					9'h02D: p2_key.r <= pressed;
					9'h02B: p2_key.f <= pressed;
					9'h023: p2_key.d <= pressed;
					9'h034: p2_key.g <= pressed;
					9'h01C: p2_key.a <= pressed;
					9'h01B: p2_key.s <= pressed;
					default: ;
				endcase
			end
		end
	end

	// ============================================================
	// Merge with joystick bits
	// ============================================================
	always_comb begin
		p1_next.up    = p1_key.up    | joystick_0[3];
		p1_next.down  = p1_key.down  | joystick_0[2];
		p1_next.left  = p1_key.left  | joystick_0[1];
		p1_next.right = p1_key.right | joystick_0[0];
		p1_next.fire1 = p1_key.ctrl  | joystick_0[4];
		p1_next.fire2 = p1_key.space | joystick_0[5];
		p1_next.start = sys_key.f1 | sys_key.one | joystick_0[6];
		p1_next.coin  = sys_key.f3 | sys_key.five | joystick_0[8];

		p2_next.up    = p2_key.r | joystick_1[3];
		p2_next.down  = p2_key.f | joystick_1[2];
		p2_next.left  = p2_key.d | joystick_1[1];
		p2_next.right = p2_key.g | joystick_1[0];
		p2_next.fire1 = p2_key.a | joystick_1[4];
		p2_next.fire2 = p2_key.s | joystick_1[5];
		// Start 2 comes from the first joystick pad
		p2_next.start = sys_key.f2 | sys_key.two | joystick_0[7];
		p2_next.coin  = 1'b0;
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			p1 <= '0;
			p2 <= '0;
		end else begin
			p1 <= p1_next;
			p2 <= p2_next;
		end
	end

endmodule

/* rtl/game_config.sv */
// Captures the game number and DIP switch bytes from download writes.
// The game byte is decoded to one-hot flags in a second register stage.

`timescale 1ns/100ps

module game_config (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  astro_cfg_pkg::download_t dl,
	output astro_cfg_pkg::game_sel_t game_sel,
	output astro_cfg_pkg::dip_bank_t dips
);

	import astro_cfg_pkg::*;

	game_id_t  game_id;
	game_sel_t sel_next;
	logic      game_wr;
	logic      dip_wr;

	// Game byte only at address 0
	assign game_wr = dl.wr && (dl.index == GAME_INDEX) && (dl.addr == '0);
	// DIP block accepts addresses 0 to 3
	assign dip_wr = dl.wr && (dl.index == DIP_INDEX) && (dl.addr[24:2] == '0);

	// First stage holds the raw game byte
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			game_id <= '0;
		end else if (game_wr) begin
			game_id <= dl.data;
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			dips <= '0;
		end else if (dip_wr) begin
			dips[dl.addr[1:0]] <= dl.data;
		end
	end

	// Decode to one-hot flags
	always_comb begin
		sel_next = '0;
		case (game_id)
			GAME_SPACEZAP: sel_next.spacezap = 1'b1;
			GAME_GORF:     sel_next.gorf     = 1'b1;
			GAME_WOW:      sel_next.wow      = 1'b1;
			GAME_ROBBY:    sel_next.robby    = 1'b1;
			// Anything outside the kept games reads no game
			default:       sel_next = '0;
		endcase
	end

	// Second stage
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			game_sel <= '0;
		end else begin
			game_sel <= sel_next;
		end
	end

endmodule

/* rtl/astro_input_pkg.sv */
// Player control definitions for the arcade input subsystem.
// Button and stick direction structs plus the analog axis numbering.

package astro_input_pkg;

	// ============================================================
	// Player buttons, active high after key and joystick merge
	// ============================================================
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire1;
		logic fire2;
		logic start;
		// Only meaningful for player 1
		logic coin;
	} player_buttons_t;

	// Stick axis mapped onto a direction pair
	typedef struct packed {
		// Low end of the axis
		logic dir0;
		// High end of the axis
		logic dir1;
		// Axis pushed to either limit
		logic move;
	} stick_dir_t;

	// ============================================================
	// Analog axis numbering
	// ============================================================
	localparam int NUM_AXES = 4;

	localparam int AXIS_P1_X = 0;
	localparam int AXIS_P1_Y = 1;
	localparam int AXIS_P2_X = 2;
	localparam int AXIS_P2_Y = 3;

endpackage

/* rtl/astro_cfg_pkg.sv */
// Game selection and DIP switch definitions for the arcade input subsystem.
// Shared by the download capture logic and the switch matrix.

package astro_cfg_pkg;

	// ============================================================
	// Game numbers as sent through the download port
	// ============================================================
	typedef logic [7:0] game_id_t;

	// Dropped games, decoded as no game
	localparam game_id_t GAME_EBASES   = 8'd1;
	localparam game_id_t GAME_SEAWOLF2 = 8'd2;
	// Kept games
	localparam game_id_t GAME_SPACEZAP = 8'd3;
	localparam game_id_t GAME_GORF     = 8'd4;
	localparam game_id_t GAME_WOW      = 8'd5;
	localparam game_id_t GAME_ROBBY    = 8'd6;

	// One-hot game flags, all low when no game is loaded
	typedef struct packed {
		logic spacezap;
		logic gorf;
		logic wow;
		logic robby;
	} game_sel_t;

	// DIP bytes 0 to 3, byte n at [n]
	localparam int NUM_DIPS = 4;
	typedef logic [NUM_DIPS-1:0][7:0] dip_bank_t;

	// Download index for the game byte and for the DIP block
	localparam logic [7:0] GAME_INDEX = 8'd1;
	localparam logic [7:0] DIP_INDEX  = 8'd254;

	// One download write, valid while wr is high
	typedef struct packed {
		logic        wr;
		logic [7:0]  index;
		logic [24:0] addr;
		logic [7:0]  data;
	} download_t;

endpackage
